/* Bender.yml */
package:
  name: idct_row

sources:
  - design/idct_pkg.sv
  - design/block_buf_if.sv
  - design/coef_fetch.sv
  - design/block_ram.sv
  - design/row_transform.sv
  - design/idct_row_top.sv
  - target: test
    files:
      - bench/sram_model.sv
      - bench/tb_idct_row.sv

/* bench/sram_model.sv */
// Behavioral model of the external frame SRAM.
// Read data appears two cycles after its address, and a write
// lands at the rising edge of any cycle with we_n_i low.
// The testbench preloads and inspects mem directly.

`timescale 1ns/10ps

module sram_model (
	input  logic                 Clock,
	input  idct_pkg::sram_addr_t addr_i,
	input  idct_pkg::sram_data_t wdata_i,
	input  logic                 we_n_i,
	output idct_pkg::sram_data_t rdata_o
);
	import idct_pkg::*;

	sram_data_t mem [2**SRAM_ADDR_W];
	sram_addr_t addr_d1;

	// two-stage read pipe
	always @(posedge Clock) begin
		addr_d1 <= addr_i;
		rdata_o <= mem[addr_d1];
	end

	always @(posedge Clock) begin
		if (!we_n_i) begin
			mem[addr_i] <= wdata_i;
		end
	end

endmodule

/* bench/tb_idct_row.sv */
// Testbench for the single-block IDCT row engine.
// Preloads coefficient blocks into the SRAM model, starts the DUT,
// records every result write on the SRAM pins and compares writes
// and memory contents against a reference of the first IDCT pass.
// Words around each block hold an address-based marker that must
// survive the run.

`timescale 1ns/10ps

module tb_idct_row;
	import idct_pkg::*;

	typedef sram_data_t blk_t [64];

	logic        Clock;
	logic        Resetn;
	logic        start_i;
	blk_x_t      block_x_i;
	blk_y_t      block_y_i;
	sram_addr_t  sram_addr;
	sram_data_t  sram_rdata;
	sram_data_t  sram_wdata;
	logic        sram_we_n;
	logic        busy;
	logic        done;
	logic [31:0] lfsr_state;
	sram_addr_t  wr_addr_q [$];
	sram_data_t  wr_data_q [$];
	int          done_cnt;
	blk_t        coefs;

	idct_row_top dut0 (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.start_i      (start_i),
		.block_x_i    (block_x_i),
		.block_y_i    (block_y_i),
		.sram_addr_o  (sram_addr),
		.sram_rdata_i (sram_rdata),
		.sram_wdata_o (sram_wdata),
		.sram_we_n_o  (sram_we_n),
		.busy_o       (busy),
		.done_o       (done)
	);

	sram_model sram0 (
		.Clock   (Clock),
		.addr_i  (sram_addr),
		.wdata_i (sram_wdata),
		.we_n_i  (sram_we_n),
		.rdata_o (sram_rdata)
	);

	always #5 Clock = ~Clock;

	// write and done monitor, sampled mid-cycle
	always @(negedge Clock) begin
		if (Resetn === 1'b1) begin
			if (sram_we_n === 1'b0) begin
				wr_addr_q.push_back(sram_addr);
				wr_data_q.push_back(sram_wdata);
			end
			if (done === 1'b1) begin
				done_cnt++;
			end
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input sram_data_t got, input sram_data_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input sram_addr_t got, input sram_addr_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, got, exp));
		end
	endtask

	// right-shift Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v[i] = lfsr_state[0];
		end
	endtask

	task automatic random_block(output blk_t s);
		logic [31:0] v;
		for (int i = 0; i < 64; i++) begin
			draw_bits(12, v);
			s[i] = sram_data_t'({{4{v[11]}}, v[11:0]});
		end
	endtask

	function automatic sram_addr_t pix_addr(sram_addr_t base, int y, int x);
		return base + sram_addr_t'(y * int'(ROW_STRIDE) + x);
	endfunction

	function automatic bit on_image(int y, int x);
		return y >= 0 && y < BLOCKS_Y * BLOCK_DIM && x >= 0 && x < BLOCKS_X * BLOCK_DIM;
	endfunction

	function automatic sram_data_t marker_of(sram_addr_t a);
		return a[15:0] ^ {a[17:16], 14'h0} ^ 16'h3c5a;
	endfunction

	// T[r][c] = sum over k of S[r][k] * C[k][c], then >>> SHIFT and saturate
	function automatic blk_t ref_t(blk_t s);
		blk_t t;
		acc_t sum;
		acc_t q;
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				sum = 0;
				for (int k = 0; k < 8; k++) begin
					sum = sum + acc_t'(s[r * 8 + k]) * acc_t'(COS_TABLE[k * 8 + c]);
				end
				q = sum >>> SHIFT;
				if (q > 32767) begin
					t[r * 8 + c] = 16'sh7fff;
				end else if (q < -32768) begin
					t[r * 8 + c] = 16'sh8000;
				end else begin
					t[r * 8 + c] = q[15:0];
				end
			end
		end
		return t;
	endfunction

	task automatic mark_window(input int bx, input int by);
		sram_addr_t a;
		for (int y = by * 8 - 1; y <= by * 8 + 8; y++) begin
			for (int x = bx * 8 - 1; x <= bx * 8 + 8; x++) begin
				if (on_image(y, x)) begin
					a = pix_addr(RESULT_BASE, y, x);
					sram0.mem[a] = marker_of(a);
				end
			end
		end
	endtask

	task automatic check_window(input int bx, input int by, input bit skip_block);
		sram_addr_t a;
		bit         in_blk;
		for (int y = by * 8 - 1; y <= by * 8 + 8; y++) begin
			for (int x = bx * 8 - 1; x <= bx * 8 + 8; x++) begin
				in_blk = y >= by * 8 && y < by * 8 + 8 && x >= bx * 8 && x < bx * 8 + 8;
				if (on_image(y, x) && !(skip_block && in_blk)) begin
					a = pix_addr(RESULT_BASE, y, x);
					check_word($sformatf("marker word %0d", a), sram0.mem[a], marker_of(a));
				end
			end
		end
	endtask

	task automatic place_block(input int bx, input int by, input blk_t s);
		for (int i = 0; i < 64; i++) begin
			sram0.mem[pix_addr(COEF_BASE, by * 8 + i / 8, bx * 8 + i % 8)] = s[i];
		end
		mark_window(bx, by);
	endtask

	task automatic launch_block(input int bx, input int by);
		wr_addr_q.delete();
		wr_data_q.delete();
		done_cnt = 0;
		@(posedge Clock);
		start_i <= 1'b1;
		block_x_i <= blk_x_t'(bx);
		block_y_i <= blk_y_t'(by);
		@(posedge Clock);
		start_i <= 1'b0;
		@(negedge Clock);
		check_bit("busy_o", busy, 1'b1);
		check_addr("sram_addr_o", sram_addr, pix_addr(COEF_BASE, by * 8, bx * 8));
	endtask

	task automatic finish_block();
		int n;
		n = 0;
		do begin
			@(negedge Clock);
			n++;
			if (n > 3000) begin
				abort_run("timed out waiting for done_o");
			end
		end while (done !== 1'b1);
		check_bit("busy_o", busy, 1'b0);
		@(negedge Clock);
		check_bit("done_o", done, 1'b0);
	endtask

	task automatic check_results(input int bx, input int by, input blk_t s);
		blk_t       exp;
		sram_addr_t a;
		exp = ref_t(s);
		if (wr_addr_q.size() != 64) begin
			abort_run($sformatf("expected 64 result writes but saw %0d", wr_addr_q.size()));
		end
		if (done_cnt != 1) begin
			abort_run($sformatf("expected one done_o pulse but saw %0d", done_cnt));
		end
		for (int i = 0; i < 64; i++) begin
			a = pix_addr(RESULT_BASE, by * 8 + i / 8, bx * 8 + i % 8);
			check_addr("sram_addr_o", wr_addr_q[i], a);
			check_word("sram_wdata_o", wr_data_q[i], exp[i]);
			check_word($sformatf("result word %0d", a), sram0.mem[a], exp[i]);
		end
		check_window(bx, by, 1'b1);
	endtask

	initial begin
		Clock = 1'b0;
		Resetn = 1'b0;
		start_i = 1'b0;
		block_x_i = '0;
		block_y_i = '0;
		lfsr_state = 32'd93395;
		done_cnt = 0;
		repeat (4) @(posedge Clock);
		Resetn <= 1'b1;

		// idle after reset
		repeat (3) @(negedge Clock);
		check_bit("busy_o", busy, 1'b0);
		check_bit("done_o", done, 1'b0);
		check_bit("sram_we_n_o", sram_we_n, 1'b1);

		coefs = '{default: 16'sd0};
		place_block(0, 0, coefs);
		launch_block(0, 0);
		finish_block();
		check_results(0, 0, coefs);

		random_block(coefs);
		place_block(5, 3, coefs);
		launch_block(5, 3);
		finish_block();
		check_results(5, 3, coefs);

		// bottom right corner of the frame
		random_block(coefs);
		place_block(39, 29, coefs);
		launch_block(39, 29);
		finish_block();
		check_results(39, 29, coefs);

		// signs follow C[k][r], flipped on odd rows, so the diagonal saturates
		for (int i = 0; i < 64; i++) begin
			if ((COS_TABLE[(i % 8) * 8 + i / 8] >= 0) ^ ((i / 8) % 2 == 1)) begin
				coefs[i] = 16'sh7fff;
			end else begin
				coefs[i] = 16'sh8000;
			end
		end
		place_block(17, 11, coefs);
		launch_block(17, 11);
		finish_block();
		check_results(17, 11, coefs);
		check_word("T[0][0]", sram0.mem[pix_addr(RESULT_BASE, 88, 136)], 16'sh7fff);
		check_word("T[1][1]", sram0.mem[pix_addr(RESULT_BASE, 89, 137)], 16'sh8000);

		// second start during the fetch must be ignored
		random_block(coefs);
		place_block(22, 7, coefs);
		mark_window(10, 10);
		launch_block(22, 7);
		repeat (10) @(negedge Clock);
		check_bit("busy_o", busy, 1'b1);
		@(posedge Clock);
		start_i <= 1'b1;
		block_x_i <= blk_x_t'(10);
		block_y_i <= blk_y_t'(10);
		@(posedge Clock);
		start_i <= 1'b0;
		block_x_i <= blk_x_t'(22);
		block_y_i <= blk_y_t'(7);
		finish_block();
		repeat (100) @(negedge Clock);
		check_results(22, 7, coefs);
		check_window(10, 10, 1'b0);

		$display("** PASS **");
		$finish;
	end

endmodule

/* design/block_buf_if.sv */
// Link between the coefficient fetcher, the block buffer and the
// row transform. The fetcher writes, the transform reads, and the
// buffer answers a read address with data one cycle later.

`timescale 1ns/10ps

interface block_buf_if;
	import idct_pkg::*;

	buf_addr_t  wr_addr;
	sram_data_t wr_data;
	logic       wr_en;
	buf_addr_t  rd_addr;
	sram_data_t rd_data;

	modport fetch (
		output wr_addr, wr_data, wr_en
	);

	modport ram (
		input  wr_addr, wr_data, wr_en, rd_addr,
		output rd_data
	);

	modport xform (
		output rd_addr,
		input  rd_data
	);

endinterface

/* design/block_ram.sv */
// On-chip block buffer holding the 64 coefficients of one block.
// One synchronous write port fed by the fetcher and one read port
// whose data appears the cycle after the address.

`timescale 1ns/10ps

module block_ram (
	input logic     Clock,
	block_buf_if.ram bbuf
);
	import idct_pkg::*;

	sram_data_t mem [2**BUF_ADDR_W];

	always_ff @(posedge Clock) begin
		if (bbuf.wr_en) begin
			mem[bbuf.wr_addr] <= bbuf.wr_data;
		end
	end

	// registered read
	always_ff @(posedge Clock) begin
		bbuf.rd_data <= mem[bbuf.rd_addr];
	end

endmodule

/* design/coef_fetch.sv */
// Block fetcher and owner of the SRAM port.
// An accepted start reads the 64 coefficients of the selected block
// in row-major order, one address per cycle, and writes each word to
// the block buffer as it returns two cycles later. fill_done_o pulses
// after the last buffer write. While idle the result writes of the
// transform pass through to the SRAM pins.

`timescale 1ns/10ps

module coef_fetch (
	input  logic                 Clock,
	input  logic                 Resetn,
	input  logic                 start_i,
	input  idct_pkg::blk_x_t     block_x_i,
	input  idct_pkg::blk_y_t     block_y_i,
	input  logic                 busy_i,
	output idct_pkg::sram_addr_t sram_addr_o,
	input  idct_pkg::sram_data_t sram_rdata_i,
	output idct_pkg::sram_data_t sram_wdata_o,
	output logic                 sram_we_n_o,
	input  idct_pkg::sram_addr_t res_addr_i,
	input  idct_pkg::sram_data_t res_data_i,
	input  logic                 res_we_i,
	block_buf_if.fetch           bbuf,
	output logic                 fetching_o,
	output logic                 fill_done_o
);
	import idct_pkg::*;

	logic       start_ok;
	logic       issuing;
	logic [2:0] row_cnt;
	logic [2:0] col_cnt;
	sram_addr_t row_addr;
	buf_addr_t  idx_d1;
	buf_addr_t  idx_d2;
	logic       vld_d1;
	logic       vld_d2;

	assign start_ok = start_i && !busy_i;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			fetching_o <= 1'b0;
			issuing <= 1'b0;
			row_cnt <= 3'd0;
			col_cnt <= 3'd0;
			vld_d1 <= 1'b0;
			vld_d2 <= 1'b0;
			fill_done_o <= 1'b0;
		end else begin
			vld_d1 <= issuing;
			vld_d2 <= vld_d1;
			fill_done_o <= vld_d2 && (idx_d2 == '1);
			if (start_ok) begin
				fetching_o <= 1'b1;
				issuing <= 1'b1;
				row_cnt <= 3'd0;
				col_cnt <= 3'd0;
			end else begin
				// stays high until the buffer is full
				if (fill_done_o) begin
					fetching_o <= 1'b0;
				end
				if (issuing) begin
					col_cnt <= col_cnt + 3'd1;
					if (col_cnt == 3'd7) begin
						row_cnt <= row_cnt + 3'd1;
						if (row_cnt == 3'd7) begin
							issuing <= 1'b0;
						end
					end
				end
			end
		end
	end

	// buffer index follows the SRAM read latency
	always_ff @(posedge Clock) begin
		idx_d1 <= {row_cnt, col_cnt};
		idx_d2 <= idx_d1;
		if (start_ok) begin
			row_addr <= blk_origin(COEF_BASE, block_x_i, block_y_i);
		end else if (issuing && col_cnt == 3'd7) begin
			row_addr <= row_addr + ROW_STRIDE;
		end
	end

	assign bbuf.wr_addr = idx_d2;
	assign bbuf.wr_data = sram_rdata_i;
	assign bbuf.wr_en = vld_d2;

	always_comb begin
		if (fetching_o) begin
			sram_addr_o = row_addr + sram_addr_t'(col_cnt);
			sram_wdata_o = '0;
			sram_we_n_o = 1'b1;
		end else begin
			sram_addr_o = res_addr_i;
			sram_wdata_o = res_data_i;
			sram_we_n_o = ~res_we_i;
		end
	end

endmodule

/* design/idct_pkg.sv */
// Shared definitions for the single-block IDCT row engine.
// Holds the SRAM memory map, word widths, block geometry and the
// cosine basis table, scaled by 4096, used by the row transform.
// Modules and the interface pull it in with a wildcard import.

package idct_pkg;

	localparam int SRAM_ADDR_W = 18;
	localparam int SRAM_DATA_W = 16;

	typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;
	typedef logic signed [SRAM_DATA_W-1:0] sram_data_t;

	// segment bases and image row pitch, in words
	localparam sram_addr_t COEF_BASE = 18'd76800;
	localparam sram_addr_t RESULT_BASE = 18'd0;
	localparam sram_addr_t ROW_STRIDE = 18'd320;

	localparam int BLOCK_DIM = 8;
	localparam int BLOCKS_X = 40;
	localparam int BLOCKS_Y = 30;

	typedef logic [5:0] blk_x_t;
	typedef logic [4:0] blk_y_t;

	// buffer index is {row, col}
	localparam int BUF_ADDR_W = 6;
	typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

	typedef logic signed [31:0] acc_t;
	typedef logic signed [15:0] cos_t;

	localparam int SHIFT = 8;

	// C[k][c] at index k*8 + c
	localparam cos_t COS_TABLE [64] = '{
		16'sd1448,  16'sd1448,  16'sd1448,  16'sd1448,
		16'sd1448,  16'sd1448,  16'sd1448,  16'sd1448,
		16'sd2008,  16'sd1702,  16'sd1137,  16'sd399,
		-16'sd399,  -16'sd1137, -16'sd1702, -16'sd2008,
		16'sd1892,  16'sd783,   -16'sd783,  -16'sd1892,
		-16'sd1892, -16'sd783,  16'sd783,   16'sd1892,
		16'sd1702,  -16'sd399,  -16'sd2008, -16'sd1137,
		16'sd1137,  16'sd2008,  16'sd399,   -16'sd1702,
		16'sd1448,  -16'sd1448, -16'sd1448, 16'sd1448,
		16'sd1448,  -16'sd1448, -16'sd1448, 16'sd1448,
		16'sd1137,  -16'sd2008, 16'sd399,   16'sd1702,
		-16'sd1702, -16'sd399,  16'sd2008,  -16'sd1137,
		16'sd783,   -16'sd1892, 16'sd1892,  -16'sd783,
		-16'sd783,  16'sd1892,  -16'sd1892, 16'sd783,
		16'sd399,   -16'sd1137, 16'sd1702,  -16'sd2008,
		16'sd2008,  -16'sd1702, 16'sd1137,  -16'sd399
	};

	// first word of block (bx, by) in a segment starting at base
	function automatic sram_addr_t blk_origin(sram_addr_t base, blk_x_t bx, blk_y_t by);
		sram_addr_t row_off;
		sram_addr_t col_off;
		row_off = sram_addr_t'(by) * sram_addr_t'(BLOCK_DIM) * ROW_STRIDE;
		col_off = sram_addr_t'(bx) * sram_addr_t'(BLOCK_DIM);
		return base + row_off + col_off;
	endfunction

endpackage

/* design/idct_row_top.sv */
// Top level of the single-block IDCT row engine.
// A start pulse while idle selects a block; the engine fetches its
// coefficients from SRAM, runs the first IDCT pass and writes the
// scaled results back to the result segment, then pulses done_o.

`timescale 1ns/10ps

module idct_row_top (
	input  logic                 Clock,
	input  logic                 Resetn,
	input  logic                 start_i,
	input  idct_pkg::blk_x_t     block_x_i,
	input  idct_pkg::blk_y_t     block_y_i,
	output idct_pkg::sram_addr_t sram_addr_o,
	input  idct_pkg::sram_data_t sram_rdata_i,
	output idct_pkg::sram_data_t sram_wdata_o,
	output logic                 sram_we_n_o,
	output logic                 busy_o,
	output logic                 done_o
);
	import idct_pkg::*;

	logic       fill_done;
	logic       fetching;
	sram_addr_t res_addr;
	sram_data_t res_data;
	logic       res_we;

	block_buf_if bbuf0 ();

	coef_fetch fetch0 (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.start_i      (start_i),
		.block_x_i    (block_x_i),
		.block_y_i    (block_y_i),
		.busy_i       (busy_o),
		.sram_addr_o  (sram_addr_o),
		.sram_rdata_i (sram_rdata_i),
		.sram_wdata_o (sram_wdata_o),
		.sram_we_n_o  (sram_we_n_o),
		.res_addr_i   (res_addr),
		.res_data_i   (res_data),
		.res_we_i     (res_we),
		.bbuf         (bbuf0),
		.fetching_o   (fetching),
		.fill_done_o  (fill_done)
	);

	block_ram ram0 (
		.Clock (Clock),
		.bbuf  (bbuf0)
	);

	row_transform xform0 (
		.Clock       (Clock),
		.Resetn      (Resetn),
		.fill_done_i (fill_done),
		.fetching_i  (fetching),
		.bbuf        (bbuf0),
		.res_addr_o  (res_addr),
		.res_data_o  (res_data),
		.res_we_o    (res_we),
		.block_x_i   (block_x_i),
		.block_y_i   (block_y_i),
		.busy_o      (busy_o),
		.done_o      (done_o)
	);

endmodule

/* design/row_transform.sv */
// First IDCT pass over one buffered block.
// Each row is read into an eight-entry row register (9 cycles), then
// every output T[r][c] is summed over four cycles with two multiplies
// per cycle while the row register rotates by two entries. Each sum
// is shifted, saturated to 16 bits and written to the result segment
// in the cycle after its last accumulate. done_o pulses one cycle
// after the 64th write.

`timescale 1ns/10ps

module row_transform (
	input  logic                 Clock,
	input  logic                 Resetn,
	input  logic                 fill_done_i,
	input  logic                 fetching_i,
	block_buf_if.xform           bbuf,
	output idct_pkg::sram_addr_t res_addr_o,
	output idct_pkg::sram_data_t res_data_o,
	output logic                 res_we_o,
	input  idct_pkg::blk_x_t     block_x_i,
	input  idct_pkg::blk_y_t     block_y_i,
	output logic                 busy_o,
	output logic                 done_o
);
	import idct_pkg::*;

	logic       loading;
	logic       calc;
	logic       tail;
	logic [3:0] ld_cnt;
	logic [2:0] row_idx;
	logic [2:0] col_idx;
	logic [1:0] step;
	logic       out_last;
	logic       row_last;

	sram_data_t row_reg [8];
	acc_t       acc;
	acc_t       prod0;
	acc_t       prod1;
	acc_t       sum_next;
	sram_addr_t row_base;

	function automatic sram_data_t saturate(acc_t sum);
		acc_t shifted;
		shifted = sum >>> SHIFT;
		if (shifted > 32'sd32767) begin
			return 16'sh7fff;
		end else if (shifted < -32'sd32768) begin
			return -16'sh8000;
		end
		return sram_data_t'(shifted);
	endfunction

	assign out_last = calc && (step == 2'd3);
	assign row_last = out_last && (col_idx == 3'd7);

	assign busy_o = fetching_i | loading | calc | tail;

	// row word k sits in row_reg[k] after loading
	assign bbuf.rd_addr = {row_idx, ld_cnt[2:0]};

	// k = 2*step and 2*step+1, rotation keeps them in entries 0 and 1
	assign prod0 = acc_t'(row_reg[0]) * acc_t'(COS_TABLE[{step, 1'b0, col_idx}]);
	assign prod1 = acc_t'(row_reg[1]) * acc_t'(COS_TABLE[{step, 1'b1, col_idx}]);
	assign sum_next = ((step == 2'd0) ? acc_t'(0) : acc) + prod0 + prod1;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			loading <= 1'b0;
			calc <= 1'b0;
			tail <= 1'b0;
			ld_cnt <= 4'd0;
			row_idx <= 3'd0;
			col_idx <= 3'd0;
			step <= 2'd0;
			res_we_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			res_we_o <= out_last;
			done_o <= tail;
			if (fill_done_i) begin
				loading <= 1'b1;
				ld_cnt <= 4'd0;
				row_idx <= 3'd0;
			end else if (loading) begin
				if (ld_cnt == 4'd8) begin
					loading <= 1'b0;
					calc <= 1'b1;
					step <= 2'd0;
					col_idx <= 3'd0;
				end else begin
					ld_cnt <= ld_cnt + 4'd1;
				end
			end else if (calc) begin
				step <= step + 2'd1;
				if (step == 2'd3) begin
					col_idx <= col_idx + 3'd1;
				end
				if (row_last) begin
					calc <= 1'b0;
					if (row_idx == 3'd7) begin
						tail <= 1'b1;
					end else begin
						loading <= 1'b1;
						ld_cnt <= 4'd0;
						row_idx <= row_idx + 3'd1;
					end
				end
			end else if (tail) begin
				// last result goes out this cycle
				tail <= 1'b0;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (fill_done_i) begin
			row_base <= blk_origin(RESULT_BASE, block_x_i, block_y_i);
		end else if (row_last) begin
			row_base <= row_base + ROW_STRIDE;
		end

		if (loading && ld_cnt != 4'd0) begin
			row_reg[7] <= bbuf.rd_data;
			for (int i = 0; i < 7; i++) begin
				row_reg[i] <= row_reg[i + 1];
			end
		end else if (calc) begin
			for (int i = 0; i < 8; i++) begin
				row_reg[i] <= row_reg[(i + 2) % 8];
			end
		end

		if (calc) begin
			acc <= sum_next;
		end
		if (out_last) begin
			res_data_o <= saturate(sum_next);
			res_addr_o <= row_base + sram_addr_t'(col_idx);
		end
	end

endmodule

/* files.f */
design/idct_pkg.sv
design/block_buf_if.sv
design/coef_fetch.sv
design/block_ram.sv
design/row_transform.sv
design/idct_row_top.sv
bench/sram_model.sv
bench/tb_idct_row.sv
